//--- board_regs.sv
// board registers
// LED output, inverted button readback, SoC version and trace enable
`timescale 1ns/1ps
`default_nettype none

module board_regs (
	input logic clk48m,
	input logic rst,
	input soc_pkg::reg_access_t reg_access,
	input logic [soc_pkg::btn_width-1:0] btn,
	output logic [soc_pkg::led_width-1:0] led,
	output logic trace_en,
	output logic [soc_pkg::data_width-1:0] rdata
);

	always_ff @(posedge clk48m) begin
		if (rst) begin
			led <= '0;
			trace_en <= 1'b0;
		end else if (reg_access.wr) begin
			if (reg_access.idx == soc_pkg::reg_led) begin
				led <= reg_access.wdata[soc_pkg::led_width-1:0];
			end
			// version register is read only, its write side holds trace enable
			if (reg_access.idx == soc_pkg::reg_soc_ver) begin
				trace_en <= reg_access.wdata[0];
			end
		end
	end

	always_comb begin
		case (reg_access.idx)
			soc_pkg::reg_led: begin
				rdata = {{(soc_pkg::data_width - soc_pkg::led_width){1'b0}}, led};
			end
			soc_pkg::reg_btn: begin
				// buttons are active low on the board
				rdata = {{(soc_pkg::data_width - soc_pkg::btn_width){1'b0}}, ~btn};
			end
			soc_pkg::reg_soc_ver: begin
				rdata = soc_pkg::soc_version;
			end
			default: begin
				rdata = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- bus_ctrl.sv
// Wishbone classic slave control for the register bank
// decodes the address region, registers a single ack or err per
// request, forms the register write pulse and merges read data
`timescale 1ns/1ps
`default_nettype none

module bus_ctrl (
	input logic clk48m,
	input logic rst,
	input soc_pkg::wb_req_t wb_req,
	output soc_pkg::wb_rsp_t wb_rsp,
	output soc_pkg::reg_access_t reg_access,
	input logic [soc_pkg::data_width-1:0] board_rdata,
	input logic [soc_pkg::data_width-1:0] gpio_rdata,
	input logic [soc_pkg::data_width-1:0] fsel_rdata,
	output logic irq_bus_error
);

	logic req;
	logic in_region;
	logic pending;
	logic ack_q;
	logic err_q;
	logic [soc_pkg::data_width-1:0] rdata_merged;

	assign req = wb_req.cyc & wb_req.stb;
	assign in_region =
		(wb_req.adr[soc_pkg::data_width-1 -: soc_pkg::region_bits] == soc_pkg::reg_region);

	// first sample of a request opens the access, the response follows
	// one edge later, then one idle cycle before the next request
	always_ff @(posedge clk48m) begin
		if (rst) begin
			pending <= 1'b0;
			ack_q <= 1'b0;
			err_q <= 1'b0;
		end else begin
			pending <= req & ~pending & ~ack_q & ~err_q;
			ack_q <= pending & req & in_region;
			err_q <= pending & req & ~in_region;
		end
	end

	// write strobe lines up with the edge that registers ack
	always_comb begin
		reg_access.idx = wb_req.adr[soc_pkg::reg_idx_bits+1:2];
		reg_access.wdata = wb_req.dat;
		reg_access.wr = pending & req & in_region & wb_req.we & wb_req.sel[0];
	end

	// unowned indices return zero from every module
	assign rdata_merged = board_rdata | gpio_rdata | fsel_rdata;

	always_comb begin
		wb_rsp.ack = ack_q;
		wb_rsp.err = err_q;
		if (err_q) begin
			wb_rsp.dat = soc_pkg::bus_error_word;
		end else if (ack_q) begin
			wb_rsp.dat = rdata_merged;
		end else begin
			wb_rsp.dat = '0;
		end
	end

	// bus error interrupt pulses with err
	assign irq_bus_error = err_q;

endmodule

`default_nettype wire

//--- flash_select.sv
// flash select sequencer
// latches the flash select data bit, then pulses the select clock
// from a short countdown; a write carrying the key also queues an
// FPGA reload that pulls programn once the countdown expires
`timescale 1ns/1ps
`default_nettype none

module flash_select (
	input logic clk48m,
	input logic rst,
	input soc_pkg::reg_access_t reg_access,
	output logic fsel_d,
	output logic fsel_c,
	output logic programn,
	output logic [soc_pkg::data_width-1:0] rdata
);

	logic sel_wr;
	logic [soc_pkg::fsel_cnt_bits-1:0] fsel_cnt;
	logic reload_armed;
	logic reload;

	assign sel_wr = reg_access.wr && (reg_access.idx == soc_pkg::reg_flash_sel);

	always_ff @(posedge clk48m) begin
		if (rst) begin
			fsel_d <= 1'b0;
			fsel_cnt <= '0;
			reload_armed <= 1'b0;
			reload <= 1'b0;
		end else if (sel_wr) begin
			// a rewrite restarts the countdown
			fsel_d <= reg_access.wdata[0];
			fsel_cnt <= soc_pkg::fsel_delay_start;
			if (reg_access.wdata[soc_pkg::data_width-1:8] == soc_pkg::fsel_key) begin
				reload_armed <= 1'b1;
			end
		end else if (fsel_cnt != '0) begin
			fsel_cnt <= fsel_cnt - 1'b1;
			if (fsel_cnt == 1 && reload_armed) begin
				reload <= 1'b1;
			end
		end
	end

	// d is stable for two cycles before the select clock rises
	assign fsel_c = (fsel_cnt == 5) || (fsel_cnt == 4) || (fsel_cnt == 3);
	assign programn = ~reload;

	assign rdata = (reg_access.idx == soc_pkg::reg_flash_sel) ?
		{{(soc_pkg::data_width - 1){1'b0}}, fsel_d} : '0;

endmodule

`default_nettype wire

//--- gpio_regs.sv
// general and extension I/O register banks
// each bank has in, out and oe registers plus write-to-set and
// write-to-clear views of out; the extension word is packed through
// its field view (sao1, sao2, pmod, irda_sd, usb_vdet)
`timescale 1ns/1ps
`default_nettype none

module gpio_regs (
	input logic clk48m,
	input logic rst,
	input soc_pkg::reg_access_t reg_access,
	input logic [soc_pkg::genio_width-1:0] genio_in,
	output logic [soc_pkg::genio_width-1:0] genio_out,
	output logic [soc_pkg::genio_width-1:0] genio_oe,
	input logic [soc_pkg::sao_width-1:0] sao1_in,
	input logic [soc_pkg::sao_width-1:0] sao2_in,
	input logic [soc_pkg::pmod_width-1:0] pmod_in,
	input logic usb_vdet,
	output soc_pkg::gpext_pins_t gpext_out,
	output soc_pkg::gpext_pins_t gpext_oe,
	output logic [soc_pkg::data_width-1:0] rdata
);

	soc_pkg::gpext_word_u ext_wr;
	soc_pkg::gpext_word_u ext_in;
	soc_pkg::gpext_word_u ext_out;
	soc_pkg::gpext_word_u ext_oe;
	soc_pkg::gpext_word_u ext_nxt;
	logic [soc_pkg::data_width-1:0] genio_word;
	logic [soc_pkg::data_width-1:0] genio_nxt;

	// next out value for one bank: replace, set or clear
	function automatic logic [soc_pkg::data_width-1:0] out_next(
		input logic [soc_pkg::data_width-1:0] cur,
		input logic [soc_pkg::data_width-1:0] wdata,
		input logic [soc_pkg::reg_idx_bits-1:0] idx,
		input logic [soc_pkg::reg_idx_bits-1:0] idx_out,
		input logic [soc_pkg::reg_idx_bits-1:0] idx_set,
		input logic [soc_pkg::reg_idx_bits-1:0] idx_clr
	);
		if (idx == idx_out) begin
			return wdata;
		end else if (idx == idx_set) begin
			return cur | wdata;
		end else if (idx == idx_clr) begin
			return cur & ~wdata;
		end
		return cur;
	endfunction

	always_comb begin
		ext_wr.raw = reg_access.wdata;

		ext_in.raw = '0;
		ext_in.f.usb_vdet = usb_vdet;
		ext_in.f.pmod = pmod_in;
		ext_in.f.sao2 = sao2_in;
		ext_in.f.sao1 = sao1_in;

		ext_out.raw = '0;
		ext_out.f.irda_sd = gpext_out.irda_sd;
		ext_out.f.pmod = gpext_out.pmod;
		ext_out.f.sao2 = gpext_out.sao2;
		ext_out.f.sao1 = gpext_out.sao1;

		// no oe for irda_sd
		ext_oe.raw = '0;
		ext_oe.f.pmod = gpext_oe.pmod;
		ext_oe.f.sao2 = gpext_oe.sao2;
		ext_oe.f.sao1 = gpext_oe.sao1;

		genio_word = {{(soc_pkg::data_width - soc_pkg::genio_width){1'b0}}, genio_out};
		genio_nxt = out_next(genio_word, reg_access.wdata, reg_access.idx,
			soc_pkg::reg_genio_out, soc_pkg::reg_genio_w2s, soc_pkg::reg_genio_w2c);
		ext_nxt.raw = out_next(ext_out.raw, reg_access.wdata, reg_access.idx,
			soc_pkg::reg_gpext_out, soc_pkg::reg_gpext_w2s, soc_pkg::reg_gpext_w2c);
	end

	always_ff @(posedge clk48m) begin
		if (rst) begin
			genio_out <= '0;
			genio_oe <= '0;
			gpext_out <= '0;
			// irda transceiver starts in shutdown
			gpext_out.irda_sd <= 1'b1;
			gpext_oe <= '0;
		end else if (reg_access.wr) begin
			genio_out <= genio_nxt[soc_pkg::genio_width-1:0];
			gpext_out.irda_sd <= ext_nxt.f.irda_sd;
			gpext_out.pmod <= ext_nxt.f.pmod;
			gpext_out.sao2 <= ext_nxt.f.sao2;
			gpext_out.sao1 <= ext_nxt.f.sao1;
			if (reg_access.idx == soc_pkg::reg_genio_oe) begin
				genio_oe <= reg_access.wdata[soc_pkg::genio_width-1:0];
			end
			if (reg_access.idx == soc_pkg::reg_gpext_oe) begin
				gpext_oe.pmod <= ext_wr.f.pmod;
				gpext_oe.sao2 <= ext_wr.f.sao2;
				gpext_oe.sao1 <= ext_wr.f.sao1;
			end
		end
	end

	always_comb begin
		case (reg_access.idx)
			soc_pkg::reg_genio_in: begin
				rdata = {{(soc_pkg::data_width - soc_pkg::genio_width){1'b0}}, genio_in};
			end
			soc_pkg::reg_genio_out: rdata = genio_word;
			soc_pkg::reg_genio_oe: begin
				rdata = {{(soc_pkg::data_width - soc_pkg::genio_width){1'b0}}, genio_oe};
			end
			soc_pkg::reg_gpext_in: rdata = ext_in.raw;
			soc_pkg::reg_gpext_out: rdata = ext_out.raw;
			soc_pkg::reg_gpext_oe: rdata = ext_oe.raw;
			default: rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the register bank testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_soc -f sim.f -Mdir obj_dir -o sim_tb \
	> build.log 2>&1 \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| { echo "build or run failed, see build.log and sim.log"; exit 1; }
grep -qx "TEST OK" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

//--- sim.f
soc_pkg.sv
bus_ctrl.sv
board_regs.sv
gpio_regs.sv
flash_select.sv
soc_periph.sv
soc_checker.sv
soc_assert.sv
tb_soc.sv

//--- soc_assert.sv
// Wishbone protocol assertions for the bus control block
`timescale 1ns/1ps
`default_nettype none

module soc_assert (
	input logic clk48m,
	input logic rst,
	input soc_pkg::wb_req_t wb_req,
	input soc_pkg::wb_rsp_t wb_rsp,
	input soc_pkg::reg_access_t reg_access
);

	single_rsp: assert property (@(posedge clk48m) disable iff (rst)
		!(wb_rsp.ack && wb_rsp.err))
		else $error("ack and err high in the same cycle");

	rsp_needs_req: assert property (@(posedge clk48m) disable iff (rst)
		(wb_rsp.ack || wb_rsp.err) |-> (wb_req.cyc && wb_req.stb))
		else $error("response without a request");

	ack_one_cycle: assert property (@(posedge clk48m) disable iff (rst)
		wb_rsp.ack |=> !wb_rsp.ack)
		else $error("ack high in two consecutive cycles");

	wr_one_cycle: assert property (@(posedge clk48m) disable iff (rst)
		reg_access.wr |=> !reg_access.wr)
		else $error("register write strobe longer than one cycle");

endmodule

bind bus_ctrl soc_assert u_assert (
	.clk48m(clk48m),
	.rst(rst),
	.wb_req(wb_req),
	.wb_rsp(wb_rsp),
	.reg_access(reg_access)
);

`default_nettype wire

//--- soc_checker.sv
// response and pin checker for the peripheral register bank
// watches the Wishbone response and the output pins, compares them with
// the values that the testbench presents, and counts the mismatches
`timescale 1ns/1ps
`default_nettype none

module soc_checker (
	input logic clk48m,
	input logic rst,
	input soc_pkg::wb_req_t wb_req,
	input soc_pkg::wb_rsp_t wb_rsp,
	input logic irq_bus_error,
	input logic [soc_pkg::led_width-1:0] led,
	input logic trace_en,
	input logic [soc_pkg::genio_width-1:0] genio_out,
	input logic [soc_pkg::genio_width-1:0] genio_oe,
	input soc_pkg::gpext_pins_t gpext_out,
	input soc_pkg::gpext_pins_t gpext_oe,
	input logic fsel_d,
	input logic fsel_c,
	input logic programn,
	// 0 ack, 1 ack with read data, 2 err, 3 ack then flash select sequence
	input logic [1:0] bus_kind,
	input logic [31:0] exp_data,
	input logic [8*16-1:0] test_name,
	input logic pin_chk,
	input logic [3:0] pin_sel,
	input logic report,
	output logic [31:0] errors
);

	int checks = 0;
	int value_errors = 0;
	int proto_errors = 0;
	int wait_cnt = 0;
	int fsel_step = 0;

	assign errors = value_errors + proto_errors;

	function automatic logic [31:0] pin_value(input logic [3:0] group);
		logic [31:0] v;
		v = '0;
		case (group)
			4'd0: v[soc_pkg::led_width-1:0] = led;
			4'd1: v[0] = trace_en;
			4'd2: v[soc_pkg::genio_width-1:0] = genio_out;
			4'd3: v[soc_pkg::genio_width-1:0] = genio_oe;
			4'd4: v[$bits(soc_pkg::gpext_pins_t)-1:0] = gpext_out;
			4'd5: v[$bits(soc_pkg::gpext_pins_t)-1:0] = gpext_oe;
			4'd6: v[0] = fsel_d;
			4'd7: v[0] = fsel_c;
			4'd8: v[0] = programn;
			default: v = 32'hffff_ffff;
		endcase
		return v;
	endfunction

	task automatic compare(input logic [31:0] expv, input logic [31:0] actv);
		checks++;
		if (expv !== actv) begin
			value_errors++;
			$display("CHECK FAILED %0s expected %08h actual %08h", test_name, expv, actv);
		end
	endtask

	always @(posedge clk48m) begin
		if (rst) begin
			wait_cnt = 0;
			fsel_step = 0;
		end else begin
			if (wb_rsp.ack && wb_rsp.err) begin
				proto_errors++;
				$display("protocol error in %0s: ack and err high together", test_name);
			end else if (wb_rsp.ack) begin
				if (bus_kind == 2'd2) begin
					proto_errors++;
					$display("protocol error in %0s: ack where err was expected", test_name);
				end else begin
					if (bus_kind == 2'd1) compare(exp_data, wb_rsp.dat);
					// step 1 is the cycle right after the write edge
					if (bus_kind == 2'd3) fsel_step = 1;
				end
			end else if (wb_rsp.err) begin
				if (bus_kind != 2'd2) begin
					proto_errors++;
					$display("protocol error in %0s: err on a mapped access", test_name);
				end else begin
					compare(exp_data, wb_rsp.dat);
					compare(32'd1, {31'd0, irq_bus_error});
				end
			end

			// the interrupt only pulses together with err
			if (irq_bus_error && !wb_rsp.err) begin
				proto_errors++;
				$display("protocol error in %0s: bus error interrupt without err", test_name);
			end

			if (wb_rsp.ack || wb_rsp.err) begin
				wait_cnt = 0;
			end else if (wb_req.cyc && wb_req.stb) begin
				wait_cnt++;
				if (wait_cnt == 4) begin
					proto_errors++;
					$display("protocol error in %0s: no response within 4 cycles", test_name);
				end
			end else begin
				wait_cnt = 0;
			end

			// exp_data bit 0 is fsel_d, bit 1 says a reload is due
			if (fsel_step != 0) begin
				compare({31'd0, exp_data[0]}, {31'd0, fsel_d});
				compare({31'd0, fsel_step >= 3 && fsel_step <= 5}, {31'd0, fsel_c});
				compare({31'd0, !(exp_data[1] && fsel_step >= 8)}, {31'd0, programn});
				fsel_step = (fsel_step == 9) ? 0 : fsel_step + 1;
			end

			if (pin_chk) compare(exp_data, pin_value(pin_sel));
		end
	end

	always @(posedge report) begin
		$display("checks %0d, value errors %0d, protocol errors %0d",
			checks, value_errors, proto_errors);
	end

endmodule

`default_nettype wire

//--- soc_periph.sv
// peripheral subsystem top
// Wishbone slave port in front of the misc register bank:
// board registers, general and extension I/O, flash select
`timescale 1ns/1ps
`default_nettype none

module soc_periph (
	input logic clk48m,
	input logic rst,
	input soc_pkg::wb_req_t wb_req,
	output soc_pkg::wb_rsp_t wb_rsp,
	output logic irq_bus_error,
	input logic [soc_pkg::btn_width-1:0] btn,
	output logic [soc_pkg::led_width-1:0] led,
	output logic trace_en,
	input logic [soc_pkg::genio_width-1:0] genio_in,
	output logic [soc_pkg::genio_width-1:0] genio_out,
	output logic [soc_pkg::genio_width-1:0] genio_oe,
	input logic [soc_pkg::sao_width-1:0] sao1_in,
	input logic [soc_pkg::sao_width-1:0] sao2_in,
	input logic [soc_pkg::pmod_width-1:0] pmod_in,
	input logic usb_vdet,
	output soc_pkg::gpext_pins_t gpext_out,
	output soc_pkg::gpext_pins_t gpext_oe,
	output logic fsel_d,
	output logic fsel_c,
	output logic programn
);

	soc_pkg::reg_access_t reg_access;
	logic [soc_pkg::data_width-1:0] board_rdata;
	logic [soc_pkg::data_width-1:0] gpio_rdata;
	logic [soc_pkg::data_width-1:0] fsel_rdata;

	bus_ctrl u_bus_ctrl (
		.clk48m(clk48m),
		.rst(rst),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.reg_access(reg_access),
		.board_rdata(board_rdata),
		.gpio_rdata(gpio_rdata),
		.fsel_rdata(fsel_rdata),
		.irq_bus_error(irq_bus_error)
	);

	board_regs u_board_regs (
		.clk48m(clk48m),
		.rst(rst),
		.reg_access(reg_access),
		.btn(btn),
		.led(led),
		.trace_en(trace_en),
		.rdata(board_rdata)
	);

	gpio_regs u_gpio_regs (
		.clk48m(clk48m),
		.rst(rst),
		.reg_access(reg_access),
		.genio_in(genio_in),
		.genio_out(genio_out),
		.genio_oe(genio_oe),
		.sao1_in(sao1_in),
		.sao2_in(sao2_in),
		.pmod_in(pmod_in),
		.usb_vdet(usb_vdet),
		.gpext_out(gpext_out),
		.gpext_oe(gpext_oe),
		.rdata(gpio_rdata)
	);

	flash_select u_flash_select (
		.clk48m(clk48m),
		.rst(rst),
		.reg_access(reg_access),
		.fsel_d(fsel_d),
		.fsel_c(fsel_c),
		.programn(programn),
		.rdata(fsel_rdata)
	);

endmodule

`default_nettype wire

//--- soc_pkg.sv
// peripheral register bank definitions
// bus width, region decode, register map, pin widths, bus structs
// and the decoded views of the extension I/O word
`default_nettype none

package soc_pkg;

	localparam int unsigned data_width = 32;
	localparam int unsigned region_bits = 4;
	localparam logic [region_bits-1:0] reg_region = 4'h2;

	// register index, word address bits 6:2
	localparam int unsigned reg_idx_bits = 5;
	localparam logic [reg_idx_bits-1:0] reg_led = 5'd0;
	localparam logic [reg_idx_bits-1:0] reg_btn = 5'd1;
	localparam logic [reg_idx_bits-1:0] reg_soc_ver = 5'd2;
	localparam logic [reg_idx_bits-1:0] reg_flash_sel = 5'd13;
	localparam logic [reg_idx_bits-1:0] reg_genio_in = 5'd17;
	localparam logic [reg_idx_bits-1:0] reg_genio_out = 5'd18;
	localparam logic [reg_idx_bits-1:0] reg_genio_oe = 5'd19;
	localparam logic [reg_idx_bits-1:0] reg_genio_w2s = 5'd20;
	localparam logic [reg_idx_bits-1:0] reg_genio_w2c = 5'd21;
	localparam logic [reg_idx_bits-1:0] reg_gpext_in = 5'd22;
	localparam logic [reg_idx_bits-1:0] reg_gpext_out = 5'd23;
	localparam logic [reg_idx_bits-1:0] reg_gpext_oe = 5'd24;
	localparam logic [reg_idx_bits-1:0] reg_gpext_w2s = 5'd25;
	localparam logic [reg_idx_bits-1:0] reg_gpext_w2c = 5'd26;

	localparam int unsigned led_width = 16;
	localparam int unsigned btn_width = 8;
	localparam int unsigned genio_width = 30;
	localparam int unsigned sao_width = 6;
	localparam int unsigned pmod_width = 8;

	localparam logic [data_width-1:0] soc_version = 32'h0000_8000;
	localparam logic [data_width-1:0] bus_error_word = 32'hdead_beef;

	// flash select sequencer
	localparam int unsigned fsel_cnt_bits = 3;
	localparam logic [23:0] fsel_key = 24'hd0f1a5;
	localparam logic [fsel_cnt_bits-1:0] fsel_delay_start = 3'd7;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [3:0] sel;
		logic [data_width-1:0] adr;
		logic [data_width-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic [data_width-1:0] dat;
		logic ack;
		logic err;
	} wb_rsp_t;

	typedef struct packed {
		logic [reg_idx_bits-1:0] idx;
		logic [data_width-1:0] wdata;
		logic wr;
	} reg_access_t;

	typedef struct packed {
		logic irda_sd;
		logic [pmod_width-1:0] pmod;
		logic [sao_width-1:0] sao2;
		logic [sao_width-1:0] sao1;
	} gpext_pins_t;

	// bit layout of the extension registers
	typedef struct packed {
		logic usb_vdet;
		logic irda_sd;
		logic [5:0] rsvd_hi;
		logic [pmod_width-1:0] pmod;
		logic [1:0] rsvd_mid;
		logic [sao_width-1:0] sao2;
		logic [1:0] rsvd_lo;
		logic [sao_width-1:0] sao1;
	} gpext_fields_t;

	typedef union packed {
		logic [data_width-1:0] raw;
		gpext_fields_t f;
	} gpext_word_u;

endpackage

`default_nettype wire

//--- soc_testdata.txt
# columns: cmd addr data expected name, all fields hex, name is one word
# W wr, R rd, E err, I inputs, P pin group, F flash sel, X random set/clr, Q bank model
R 20000000 00000000 00000000 rst_led
R 20000048 00000000 00000000 rst_genio_out
R 2000004c 00000000 00000000 rst_genio_oe
R 2000005c 00000000 40000000 rst_gpext_out
R 20000060 00000000 00000000 rst_gpext_oe
R 20000008 00000000 00008000 rst_soc_ver
R 20000034 00000000 00000000 rst_fsel
P 00000000 00000000 00000000 rst_led_pin
P 00000001 00000000 00000000 rst_trace
P 00000004 00000000 00100000 rst_gpext_pins
P 00000008 00000000 00000001 rst_programn
W 20000000 0000a5c3 00000000 led_wr
R 20000000 00000000 0000a5c3 led_rd
P 00000000 00000000 0000a5c3 led_pin
W 20000000 ffffffff 00000000 led_wr_all
R 20000000 00000000 0000ffff led_rd_all
W 20000008 00000001 00000000 trace_wr
P 00000001 00000000 00000001 trace_pin
R 20000008 00000000 00008000 ver_rd
W 2000004c ffffffff 00000000 genio_oe_wr
R 2000004c 00000000 3fffffff genio_oe_rd
P 00000003 00000000 3fffffff genio_oe_pin
W 20000060 ffffffff 00000000 gpext_oe_wr
R 20000060 00000000 00ff3f3f gpext_oe_rd
P 00000005 00000000 000fffff gpext_oe_pin
I 00000000 0000005a 00000000 btn_set
R 20000004 00000000 000000a5 btn_rd
I 00000001 12345678 00000000 genio_in_set
R 20000044 00000000 12345678 genio_in_rd
I 00000002 80ab1525 00000000 gpext_in_set
R 20000058 00000000 80ab1525 gpext_in_rd
W 20000048 2aaaaaaa 00000000 genio_out_wr
Q 20000048 00000000 00000000 genio_chk0
X 20000050 ffffffff 00000000 genio_set1
X 20000054 ffffffff 00000000 genio_clr1
Q 20000048 00000000 00000000 genio_chk1
X 20000050 ffffffff 00000000 genio_set2
X 20000054 0000ffff 00000000 genio_clr2
Q 20000048 00000000 00000000 genio_chk2
W 2000005c 00000000 00000000 gpext_out_wr
Q 2000005c 00000000 00000000 gpext_chk0
X 20000064 ffffffff 00000000 gpext_set1
X 20000068 0000ffff 00000000 gpext_clr1
Q 2000005c 00000000 00000000 gpext_chk1
X 20000064 ffffffff 00000000 gpext_set2
X 20000068 ffffffff 00000000 gpext_clr2
Q 2000005c 00000000 00000000 gpext_chk2
E 00000010 00000000 deadbeef err_region0
E 30000000 00000000 deadbeef err_region3
E f000007c 00000000 deadbeef err_region15
R 20000014 00000000 00000000 unmapped5
W 2000003c 12345678 00000000 unmapped_wr
R 2000003c 00000000 00000000 unmapped_rd
F 20000034 00000001 00000001 fsel_nokey1
R 20000034 00000000 00000001 fsel_rd
F 20000034 00000000 00000001 fsel_nokey0
P 00000008 00000000 00000001 prog_high
F 20000034 d0f1a501 00000000 fsel_key
P 00000008 00000000 00000000 prog_low
P 00000006 00000000 00000001 fsel_d_pin

//--- tb_soc.sv
// testbench for the peripheral register bank
// reads commands from soc_testdata.txt, acts as Wishbone master,
// drives the input pins and keeps a model of both out registers
`timescale 1ns/1ps
`default_nettype none

module tb_soc;

	logic clk48m;
	logic rst;
	soc_pkg::wb_req_t wb_req;
	soc_pkg::wb_rsp_t wb_rsp;
	logic irq_bus_error;
	logic [soc_pkg::btn_width-1:0] btn;
	logic [soc_pkg::led_width-1:0] led;
	logic trace_en;
	logic [soc_pkg::genio_width-1:0] genio_in;
	logic [soc_pkg::genio_width-1:0] genio_out;
	logic [soc_pkg::genio_width-1:0] genio_oe;
	logic [soc_pkg::sao_width-1:0] sao1_in;
	logic [soc_pkg::sao_width-1:0] sao2_in;
	logic [soc_pkg::pmod_width-1:0] pmod_in;
	logic usb_vdet;
	soc_pkg::gpext_pins_t gpext_out;
	soc_pkg::gpext_pins_t gpext_oe;
	logic fsel_d;
	logic fsel_c;
	logic programn;

	logic [1:0] bus_kind;
	logic [31:0] exp_data;
	logic [8*16-1:0] test_name;
	logic pin_chk;
	logic [3:0] pin_sel;
	logic report;
	logic [31:0] errors;
	logic file_error;
	logic [31:0] genio_model;
	logic [31:0] gpext_model;
	integer seed;

	soc_periph u_dut (
		.clk48m(clk48m), .rst(rst), .wb_req(wb_req), .wb_rsp(wb_rsp),
		.irq_bus_error(irq_bus_error), .btn(btn), .led(led), .trace_en(trace_en),
		.genio_in(genio_in), .genio_out(genio_out), .genio_oe(genio_oe),
		.sao1_in(sao1_in), .sao2_in(sao2_in), .pmod_in(pmod_in), .usb_vdet(usb_vdet),
		.gpext_out(gpext_out), .gpext_oe(gpext_oe),
		.fsel_d(fsel_d), .fsel_c(fsel_c), .programn(programn)
	);

	soc_checker u_checker (
		.clk48m(clk48m), .rst(rst), .wb_req(wb_req), .wb_rsp(wb_rsp),
		.irq_bus_error(irq_bus_error), .led(led), .trace_en(trace_en),
		.genio_out(genio_out), .genio_oe(genio_oe),
		.gpext_out(gpext_out), .gpext_oe(gpext_oe),
		.fsel_d(fsel_d), .fsel_c(fsel_c), .programn(programn),
		.bus_kind(bus_kind), .exp_data(exp_data), .test_name(test_name),
		.pin_chk(pin_chk), .pin_sel(pin_sel), .report(report), .errors(errors)
	);

	initial begin
		clk48m = 1'b0;
		forever #20 clk48m = ~clk48m;
	end

	// bits of an out register that exist as flops
	function automatic logic [31:0] bank_mask(input logic ext);
		soc_pkg::gpext_word_u m;
		m.raw = '0;
		if (ext) begin
			m.f.irda_sd = 1'b1;
			m.f.pmod = '1;
			m.f.sao2 = '1;
			m.f.sao1 = '1;
		end else begin
			m.raw[soc_pkg::genio_width-1:0] = '1;
		end
		return m.raw;
	endfunction

	function automatic logic [31:0] ext_pins(input logic [31:0] word);
		soc_pkg::gpext_word_u w;
		w.raw = word;
		return {11'd0, w.f.irda_sd, w.f.pmod, w.f.sao2, w.f.sao1};
	endfunction

	task automatic bus_access(input logic [31:0] addr, input logic [31:0] data,
		input logic we, input logic [1:0] kind, input logic [31:0] expv);
		int waited;
		@(negedge clk48m);
		bus_kind = kind;
		exp_data = expv;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we = we;
		wb_req.sel = 4'hf;
		wb_req.adr = addr;
		wb_req.dat = data;
		waited = 0;
		do begin
			@(negedge clk48m);
			waited++;
		end while (!(wb_rsp.ack || wb_rsp.err) && waited < 8);
		// held through the edge where the checker samples the response
		@(negedge clk48m);
		wb_req = '0;
	endtask

	task automatic pin_check(input logic [3:0] group, input logic [31:0] expv);
		@(negedge clk48m);
		pin_sel = group;
		exp_data = expv;
		pin_chk = 1'b1;
		@(negedge clk48m);
		pin_chk = 1'b0;
	endtask

	task automatic set_inputs(input logic [1:0] group, input logic [31:0] value);
		soc_pkg::gpext_word_u w;
		@(negedge clk48m);
		w.raw = value;
		case (group)
			2'd0: btn = value[soc_pkg::btn_width-1:0];
			2'd1: genio_in = value[soc_pkg::genio_width-1:0];
			default: begin
				usb_vdet = w.f.usb_vdet;
				pmod_in = w.f.pmod;
				sao2_in = w.f.sao2;
				sao1_in = w.f.sao1;
			end
		endcase
	endtask

	task automatic model_write(input logic [4:0] idx, input logic [31:0] data);
		case (idx)
			soc_pkg::reg_genio_out: genio_model = data & bank_mask(1'b0);
			soc_pkg::reg_genio_w2s: genio_model = (genio_model | data) & bank_mask(1'b0);
			soc_pkg::reg_genio_w2c: genio_model = genio_model & ~data;
			soc_pkg::reg_gpext_out: gpext_model = data & bank_mask(1'b1);
			soc_pkg::reg_gpext_w2s: gpext_model = (gpext_model | data) & bank_mask(1'b1);
			soc_pkg::reg_gpext_w2c: gpext_model = gpext_model & ~data;
			default: ;
		endcase
	endtask

	task automatic run_command(input logic [7:0] cmd, input logic [31:0] addr,
		input logic [31:0] data, input logic [31:0] expv, input logic [8*16-1:0] name);
		logic [4:0] idx;
		logic [31:0] rnd;
		idx = addr[6:2];
		test_name = name;
		case (cmd)
			"W": begin
				bus_access(addr, data, 1'b1, 2'd0, 32'd0);
				model_write(idx, data);
			end
			"R": bus_access(addr, 32'd0, 1'b0, 2'd1, expv);
			"E": bus_access(addr, 32'd0, 1'b0, 2'd2, expv);
			"I": set_inputs(addr[1:0], data);
			"P": pin_check(addr[3:0], expv);
			"F": begin
				// expected field is the final programn level
				bus_access(addr, data, 1'b1, 2'd3, {30'd0, expv == 32'd0, data[0]});
				repeat (10) @(negedge clk48m);
			end
			"X": begin
				rnd = $random(seed) & data;
				bus_access(addr, rnd, 1'b1, 2'd0, 32'd0);
				model_write(idx, rnd);
			end
			"Q": begin
				if (idx == soc_pkg::reg_genio_out) begin
					bus_access(addr, 32'd0, 1'b0, 2'd1, genio_model);
					pin_check(4'd2, genio_model);
				end else begin
					bus_access(addr, 32'd0, 1'b0, 2'd1, gpext_model);
					pin_check(4'd4, ext_pins(gpext_model));
				end
			end
			default: begin
				file_error = 1'b1;
				$display("unknown command in test data, test %0s", name);
			end
		endcase
	endtask

	initial begin : stimulus
		int fd;
		int n;
		int done;
		logic [7:0] cmd;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] expv;
		logic [8*16-1:0] name;
		logic [8*128-1:0] junk;
		rst = 1'b1;
		wb_req = '0;
		btn = '0;
		genio_in = '0;
		sao1_in = '0;
		sao2_in = '0;
		pmod_in = '0;
		usb_vdet = 1'b0;
		bus_kind = 2'd0;
		exp_data = '0;
		test_name = '0;
		pin_chk = 1'b0;
		pin_sel = '0;
		report = 1'b0;
		file_error = 1'b0;
		seed = 60;
		genio_model = '0;
		// irda_sd leaves reset high
		gpext_model = 32'h4000_0000;
		repeat (3) @(posedge clk48m);
		@(negedge clk48m);
		rst = 1'b0;

		fd = $fopen("soc_testdata.txt", "r");
		if (fd == 0) begin
			file_error = 1'b1;
			$display("cannot open soc_testdata.txt");
		end else begin
			done = 0;
			while (done == 0) begin
				n = $fscanf(fd, "%s", cmd);
				if (n != 1) begin
					done = 1;
				end else if (cmd == "#") begin
					n = $fgets(junk, fd);
				end else begin
					n = $fscanf(fd, "%h %h %h %s", addr, data, expv, name);
					if (n != 4) begin
						file_error = 1'b1;
						$display("malformed line in soc_testdata.txt");
						done = 1;
					end else begin
						run_command(cmd, addr, data, expv, name);
					end
				end
			end
			$fclose(fd);
		end

		report = 1'b1;
		@(negedge clk48m);
		if (errors == 0 && !file_error) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		int fd_count;
		int lines;
		logic [8*128-1:0] junk;
		lines = 0;
		fd_count = $fopen("soc_testdata.txt", "r");
		if (fd_count != 0) begin
			while ($fgets(junk, fd_count) != 0) lines++;
			$fclose(fd_count);
		end
		repeat (3 + lines * 20) @(posedge clk48m);
		$display("watchdog expired after %0d clock cycles, run stopped", 3 + lines * 20);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire
